//--- flist.f
+incdir+sim
source/decode_pkg.sv
source/stage_latch.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_unit.sv
source/branch_resolve.sv
source/decode_stage.sv
sim/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_decode_stage -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_decode_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- sim/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [XLEN-1:0] model_regs [NUM_REGS];
logic            model_valid;
fetch_bus_t      model_item;

function automatic decode_ctrl_t model_decode(input mips_inst_u inst);
    decode_ctrl_t c;
    int           alu;
    c = '0;
    alu = -1;  // stays negative for no register write
    c.imm = inst.i.imm;
    c.dest = inst.r.rd;
    if (inst.r.op == OPC_SPECIAL) begin
        if (inst.r.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
            if (inst.r.rs == '0) begin
                alu = (inst.r.funct == FN_SLL) ? ALU_SLL :
                      (inst.r.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                c.src1_is_sa = 1'b1;
            end
        end else if (inst.r.sa == '0) begin
            case (inst.r.funct)
                FN_ADD, FN_ADDU: alu = ALU_ADD;
                FN_SUB, FN_SUBU: alu = ALU_SUB;
                FN_SLT:          alu = ALU_SLT;
                FN_SLTU:         alu = ALU_SLTU;
                FN_AND:          alu = ALU_AND;
                FN_OR:           alu = ALU_OR;
                FN_XOR:          alu = ALU_XOR;
                FN_NOR:          alu = ALU_NOR;
                FN_SLLV:         alu = ALU_SLL;
                FN_SRLV:         alu = ALU_SRL;
                FN_SRAV:         alu = ALU_SRA;
                FN_JR: begin
                    if (inst.r.rt == '0 && inst.r.rd == '0)
                        c.br_kind = BR_JR;
                end
                FN_JALR: begin
                    if (inst.r.rt == '0) begin
                        c.br_kind = BR_JR;
                        alu = ALU_ADD;  // link value
                    end
                end
                default: ;
            endcase
        end
    end else begin
        case (inst.i.op)
            OPC_ADDI, OPC_ADDIU, OPC_LW: alu = ALU_ADD;
            OPC_SLTI:   alu = ALU_SLT;
            OPC_SLTIU:  alu = ALU_SLTU;
            OPC_ANDI:   alu = ALU_AND;
            OPC_ORI:    alu = ALU_OR;
            OPC_XORI:   alu = ALU_XOR;
            OPC_LUI: begin
                if (inst.i.rs == '0)
                    alu = ALU_LUI;
            end
            OPC_SW:     c.alu_op[ALU_ADD] = 1'b1;  // address sum, no write
            OPC_BEQ:    c.br_kind = BR_BEQ;
            OPC_BNE:    c.br_kind = BR_BNE;
            OPC_BGTZ: begin
                if (inst.i.rt == '0)
                    c.br_kind = BR_BGTZ;
            end
            OPC_BLEZ: begin
                if (inst.i.rt == '0)
                    c.br_kind = BR_BLEZ;
            end
            OPC_REGIMM: begin
                if (inst.i.rt == RT_BGEZ)
                    c.br_kind = BR_BGEZ;
                if (inst.i.rt == RT_BLTZ)
                    c.br_kind = BR_BLTZ;
            end
            OPC_J:      c.br_kind = BR_J;
            OPC_JAL: begin
                c.br_kind = BR_J;
                alu = ALU_ADD;
            end
            default: ;
        endcase
        c.zero_extend_imm = inst.i.op inside {OPC_ANDI, OPC_ORI, OPC_XORI};
        c.load_op = inst.i.op == OPC_LW;
        c.mem_we = inst.i.op == OPC_SW;
        c.src2_is_imm = c.mem_we || (alu >= 0 && inst.i.op != OPC_JAL);
        if (alu >= 0)
            c.dest = (inst.i.op == OPC_JAL) ? 5'd31 : inst.i.rt;
    end
    // jal and jalr compute pc + 8
    c.src1_is_pc = (c.br_kind inside {BR_J, BR_JR}) && alu >= 0;
    c.src2_is_8 = c.src1_is_pc;
    if (alu >= 0)
        c.alu_op[alu] = 1'b1;
    c.gr_we = alu >= 0;
    return c;
endfunction

function automatic logic [XLEN-1:0] model_operand(input logic [REG_AW-1:0] a,
                                                  input fwd_src_t es, input fwd_src_t ms,
                                                  input fwd_src_t ws, input logic es_load);
    if (a == '0)
        return '0;
    if (es.valid && es.gr_we && es.addr == a && !es_load)
        return es.value;
    if (ms.valid && ms.gr_we && ms.addr == a)
        return ms.value;
    if (ws.valid && ws.gr_we && ws.addr == a)
        return ws.value;
    return model_regs[a];
endfunction

function automatic logic model_ready_go(input mips_inst_u inst, input fwd_src_t es,
                                        input logic es_load);
    return !(es.valid && es_load && es.addr != '0
             && (es.addr == inst.r.rs || es.addr == inst.r.rt));
endfunction

function automatic br_bus_t model_branch(input logic valid, input decode_ctrl_t c,
                                         input fetch_bus_t item, input logic [XLEN-1:0] rs,
                                         input logic [XLEN-1:0] rt, input logic rg);
    br_bus_t         b;
    logic [XLEN-1:0] slot;
    logic [XLEN-1:0] sext;
    logic            cond;
    slot = item.pc + 32'd4;
    sext = {{16{c.imm[15]}}, c.imm};
    case (c.br_kind)
        BR_BEQ:      cond = rs == rt;
        BR_BNE:      cond = rs != rt;
        BR_BGEZ:     cond = $signed(rs) >= 0;
        BR_BGTZ:     cond = $signed(rs) > 0;
        BR_BLEZ:     cond = $signed(rs) <= 0;
        BR_BLTZ:     cond = $signed(rs) < 0;
        BR_J, BR_JR: cond = 1'b1;
        default:     cond = 1'b0;
    endcase
    b.stall = rg;
    b.taken = valid && cond;
    if (c.br_kind == BR_JR)
        b.target = rs;
    else if (c.br_kind == BR_J)
        b.target = {slot[31:28], item.inst.j.jidx, 2'b00};
    else
        b.target = slot + (sext << 2);
    return b;
endfunction

`endif

//--- sim/tb_decode_stage.sv
module tb_decode_stage
    import decode_pkg::*;
();

    localparam int RESET_CYCLES   = 4;
    localparam int INIT_CYCLES    = NUM_REGS - 1;  // one write per register
    localparam int RAND_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + INIT_CYCLES + RAND_CYCLES + 65;

    localparam logic [5:0] R_FUNCTS [16] = '{FN_ADDU, FN_SUBU, FN_ADD, FN_SUB, FN_SLT,
        FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV,
        FN_SRAV};
    localparam logic [5:0] I_OPS [17] = '{OPC_ADDIU, OPC_ADDI, OPC_SLTI, OPC_SLTIU, OPC_ANDI,
        OPC_ORI, OPC_XORI, OPC_LUI, OPC_LW, OPC_SW, OPC_BEQ, OPC_BNE, OPC_BGTZ, OPC_BLEZ,
        OPC_REGIMM, OPC_J, OPC_JAL};

    logic            clk;
    logic            reset;
    logic            fs_to_ds_valid;
    fetch_bus_t      fs_to_ds_bus;
    logic            ds_allowin;
    logic            es_allowin;
    fwd_src_t        es_fwd;
    fwd_src_t        ms_fwd;
    fwd_src_t        ws_fwd;
    logic            es_is_load;
    rf_write_t       ws_to_rf;
    logic            ds_to_es_valid;
    issue_bus_t      ds_to_es_bus;
    br_bus_t         br_bus;

    logic [31:0]     lcg_state = 32'hf101339c;
    int              cycles = 0;
    logic [9:0]      pc_seq;

    `include "decode_model.svh"

    decode_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic chance(input int pct);
        return int'(next_random() >> 8) % 100 < pct;
    endfunction

    // mostly low registers so sources and destinations collide
    function automatic logic [REG_AW-1:0] random_reg();
        logic [31:0] r;
        r = next_random();
        return r[31] ? r[30:26] : {2'b00, r[30:28]};
    endfunction

    function automatic fwd_src_t random_fwd();
        fwd_src_t f;
        f.valid = chance(60);
        f.gr_we = chance(70);
        f.addr = random_reg();
        f.value = next_random();
        return f;
    endfunction

    function automatic mips_inst_u random_inst();
        mips_inst_u  w;
        logic [31:0] r;
        r = next_random();
        w = next_random();
        w.r.rs = random_reg();
        w.r.rt = random_reg();
        w.r.rd = random_reg();
        if (r[31:30] == 2'b00) begin
            w.r.op = OPC_SPECIAL;
            w.r.funct = R_FUNCTS[r[27:24]];
            if (r[22:20] != '0 && (w.r.funct inside {FN_SLL, FN_SRL, FN_SRA}))
                w.r.rs = '0;
            else if (r[22:20] != '0)
                w.r.sa = '0;  // otherwise left as an illegal encoding
        end else if (r[31:29] == 3'b010) begin
            w.r.op = OPC_SPECIAL;
            w.r.funct = r[19] ? FN_JR : FN_JALR;
            w.r.rt = '0;
            w.r.sa = '0;
            if (r[19])
                w.r.rd = '0;
        end else if (r[31:28] != 4'hf) begin
            w.i.op = I_OPS[int'(r[27:23]) % 17];
            if (w.i.op == OPC_LUI)
                w.i.rs = '0;
            if (w.i.op inside {OPC_BGTZ, OPC_BLEZ})
                w.i.rt = '0;
            if (w.i.op == OPC_REGIMM)
                w.i.rt = {4'b0000, r[18]};
        end
        return w;  // raw word in the last case, mostly outside the subset
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR %0t %s: got %b expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_issue(input issue_bus_t act, input issue_bus_t exp);
        if (act !== exp) begin
            $display("ERROR %0t ds_to_es_bus: got %h expected %h", $time, act, exp);
            abort_run();
        end
    endtask

    task automatic check_br(input br_bus_t act, input br_bus_t exp, input logic with_target);
        if (act.stall !== exp.stall || act.taken !== exp.taken
                || (with_target && act.target !== exp.target)) begin
            $display("ERROR %0t br_bus: got %h expected %h", $time, act, exp);
            abort_run();
        end
    endtask

    task automatic check_outputs();
        decode_ctrl_t c;
        issue_bus_t   exp_issue;
        logic         rg;
        rg = model_ready_go(model_item.inst, es_fwd, es_is_load);
        check_flag("ds_allowin", ds_allowin, !model_valid || (rg && es_allowin));
        check_flag("ds_to_es_valid", ds_to_es_valid, model_valid && rg);
        if (model_valid) begin
            c = model_decode(model_item.inst);
            exp_issue.ctrl = c;
            exp_issue.rs_value = model_operand(model_item.inst.r.rs, es_fwd, ms_fwd, ws_fwd,
                                               es_is_load);
            exp_issue.rt_value = model_operand(model_item.inst.r.rt, es_fwd, ms_fwd, ws_fwd,
                                               es_is_load);
            exp_issue.pc = model_item.pc;
            check_issue(ds_to_es_bus, exp_issue);
            check_br(br_bus, model_branch(1'b1, c, model_item, exp_issue.rs_value,
                                          exp_issue.rt_value, rg), c.br_kind != BR_NONE);
        end else begin
            check_flag("br_bus.taken", br_bus.taken, 1'b0);
        end
    endtask

    // edge update with the inputs that were stable before it
    task automatic model_step();
        logic rg;
        rg = model_ready_go(model_item.inst, es_fwd, es_is_load);
        if (ws_to_rf.we && ws_to_rf.addr != '0)
            model_regs[ws_to_rf.addr] = ws_to_rf.data;
        if (!model_valid || (rg && es_allowin)) begin
            model_valid = fs_to_ds_valid;
            if (fs_to_ds_valid)
                model_item = fs_to_ds_bus;
        end
    endtask

    task automatic drive_reg_init(input int a);
        rf_write_t wr;
        wr.we = 1'b1;
        wr.addr = REG_AW'(a);
        wr.data = next_random();
        ws_to_rf <= wr;
    endtask

    task automatic drive_random();
        fetch_bus_t  fb;
        rf_write_t   wr;
        logic [31:0] r;
        r = next_random();
        fb.inst = random_inst();
        fb.pc = {r[31:12], pc_seq, 2'b00};
        pc_seq = pc_seq + 1'b1;
        wr.we = chance(50);
        wr.addr = random_reg();
        wr.data = next_random();
        fs_to_ds_valid <= chance(75);
        fs_to_ds_bus <= fb;
        es_allowin <= chance(70);
        es_fwd <= random_fwd();
        ms_fwd <= random_fwd();
        ws_fwd <= random_fwd();
        es_is_load <= chance(30);
        ws_to_rf <= wr;
    endtask

    initial begin
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        es_is_load = 1'b0;
        ws_to_rf = '0;
        model_valid = 1'b0;
        model_item = '0;
        pc_seq = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < INIT_CYCLES + RAND_CYCLES; n++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            model_step();
            if (n < INIT_CYCLES)
                drive_reg_init(n + 1);
            else
                drive_random();
        end
        @(negedge clk);
        check_outputs();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- source/decode_stage.sv
module decode_stage
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_to_ds_valid,
    input  fetch_bus_t fs_to_ds_bus,
    output logic       ds_allowin,
    input  logic       es_allowin,
    input  fwd_src_t   es_fwd,
    input  fwd_src_t   ms_fwd,
    input  fwd_src_t   ws_fwd,
    input  logic       es_is_load,
    input  rf_write_t  ws_to_rf,
    output logic       ds_to_es_valid,
    output issue_bus_t ds_to_es_bus,
    output br_bus_t    br_bus
);

    logic            ds_valid;
    logic            ready_go;
    fetch_bus_t      ds_item;
    decode_ctrl_t    ctrl;
    logic [XLEN-1:0] rs_value;
    logic [XLEN-1:0] rt_value;

    stage_latch u_stage_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ds_valid       (ds_valid),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_item        (ds_item)
    );

    inst_decoder u_inst_decoder (
        .inst (ds_item.inst),
        .ctrl (ctrl)
    );

    operand_unit u_operand_unit (
        .clk        (clk),
        .rs_addr    (ds_item.inst.r.rs),
        .rt_addr    (ds_item.inst.r.rt),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_is_load (es_is_load),
        .ws_to_rf   (ws_to_rf),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .ready_go   (ready_go)
    );

    branch_resolve u_branch_resolve (
        .ds_valid (ds_valid),
        .br_kind  (ctrl.br_kind),
        .imm      (ctrl.imm),
        .jidx     (ds_item.inst.j.jidx),
        .pc       (ds_item.pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ready_go),
        .br       (br_bus)
    );

    assign ds_to_es_bus = {ctrl, rs_value, rt_value, ds_item.pc};  // 141 bits to execute

endmodule

//--- source/branch_resolve.sv
module branch_resolve
    import decode_pkg::*;
(
    input  logic                 ds_valid,
    input  logic [BR_KIND_W-1:0] br_kind,
    input  logic [15:0]          imm,
    input  logic [25:0]          jidx,
    input  logic [XLEN-1:0]      pc,
    input  logic [XLEN-1:0]      rs_value,
    input  logic [XLEN-1:0]      rt_value,
    input  logic                 ready_go,
    output br_bus_t              br
);

    logic [XLEN-1:0] slot_pc;  // delay slot, base of every target
    logic [XLEN-1:0] br_offset;
    logic            rs_eq_rt, rs_lt_zero, rs_gt_zero;
    logic            cond;

    assign slot_pc    = pc + 32'd4;
    assign br_offset  = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt   = rs_value == rt_value;
    assign rs_lt_zero = rs_value[XLEN-1];
    assign rs_gt_zero = !rs_lt_zero && rs_value != '0;

    always_comb begin
        case (br_kind)
            BR_BEQ:       cond = rs_eq_rt;
            BR_BNE:       cond = !rs_eq_rt;
            BR_BGEZ:      cond = !rs_lt_zero;
            BR_BGTZ:      cond = rs_gt_zero;
            BR_BLEZ:      cond = !rs_gt_zero;
            BR_BLTZ:      cond = rs_lt_zero;
            BR_J, BR_JR:  cond = 1'b1;  // unconditional
            default:      cond = 1'b0;
        endcase
    end

    assign br.stall  = ready_go;
    assign br.taken  = cond && ds_valid;
    assign br.target = br_kind == BR_JR ? rs_value :
                       br_kind == BR_J  ? {slot_pc[31:28], jidx, 2'b00} :
                                          slot_pc + br_offset;

endmodule

//--- source/operand_unit.sv
module operand_unit
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] rs_addr,
    input  logic [REG_AW-1:0] rt_addr,
    input  fwd_src_t          es_fwd,
    input  fwd_src_t          ms_fwd,
    input  fwd_src_t          ws_fwd,
    input  logic              es_is_load,
    input  rf_write_t         ws_to_rf,
    output logic [XLEN-1:0]   rs_value,
    output logic [XLEN-1:0]   rt_value,
    output logic              ready_go
);

    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;
    logic            load_use;

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .wr     (ws_to_rf),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    function automatic logic hits(input fwd_src_t src, input logic [REG_AW-1:0] addr);
        return src.valid && src.gr_we && src.addr == addr;
    endfunction

    // youngest stage first, a load in execute has no value yet
    function automatic logic [XLEN-1:0] pick(input logic [REG_AW-1:0] addr,
                                             input logic [XLEN-1:0]   rf_data,
                                             input fwd_src_t          es,
                                             input fwd_src_t          ms,
                                             input fwd_src_t          ws,
                                             input logic              es_load);
        if (addr == '0)                     return '0;
        else if (hits(es, addr) && !es_load) return es.value;
        else if (hits(ms, addr))            return ms.value;
        else if (hits(ws, addr))            return ws.value;
        else                                return rf_data;
    endfunction

    assign rs_value = pick(rs_addr, rf_rdata1, es_fwd, ms_fwd, ws_fwd, es_is_load);
    assign rt_value = pick(rt_addr, rf_rdata2, es_fwd, ms_fwd, ws_fwd, es_is_load);

    assign load_use = es_fwd.valid && es_is_load && es_fwd.addr != '0
                   && (es_fwd.addr == rs_addr || es_fwd.addr == rt_addr);
    assign ready_go = !load_use;

endmodule

//--- source/reg_file.sv
module reg_file
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  rf_write_t         wr,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // r0 stays untouched, reads of it are masked by the operand unit
    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // old contents until the write edge
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- source/inst_decoder.sv
module inst_decoder
    import decode_pkg::*;
(
    input  mips_inst_u   inst,
    output decode_ctrl_t ctrl
);

    logic is_special, is_regimm;
    logic sa_zero, rs_zero, rt_zero, rd_zero;

    logic inst_addu, inst_subu, inst_add, inst_sub, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_addi, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic dst_is_r31, dst_is_rt;

    assign is_special = inst.r.op == OPC_SPECIAL;
    assign is_regimm  = inst.i.op == OPC_REGIMM;
    assign sa_zero    = inst.r.sa == 5'd0;
    assign rs_zero    = inst.r.rs == 5'd0;
    assign rt_zero    = inst.r.rt == 5'd0;
    assign rd_zero    = inst.r.rd == 5'd0;

    // register-register forms
    assign inst_addu = is_special && inst.r.funct == FN_ADDU && sa_zero;
    assign inst_subu = is_special && inst.r.funct == FN_SUBU && sa_zero;
    assign inst_add  = is_special && inst.r.funct == FN_ADD  && sa_zero;
    assign inst_sub  = is_special && inst.r.funct == FN_SUB  && sa_zero;
    assign inst_slt  = is_special && inst.r.funct == FN_SLT  && sa_zero;
    assign inst_sltu = is_special && inst.r.funct == FN_SLTU && sa_zero;
    assign inst_and  = is_special && inst.r.funct == FN_AND  && sa_zero;
    assign inst_or   = is_special && inst.r.funct == FN_OR   && sa_zero;
    assign inst_xor  = is_special && inst.r.funct == FN_XOR  && sa_zero;
    assign inst_nor  = is_special && inst.r.funct == FN_NOR  && sa_zero;
    assign inst_sll  = is_special && inst.r.funct == FN_SLL  && rs_zero;  // shamt form
    assign inst_srl  = is_special && inst.r.funct == FN_SRL  && rs_zero;
    assign inst_sra  = is_special && inst.r.funct == FN_SRA  && rs_zero;
    assign inst_sllv = is_special && inst.r.funct == FN_SLLV && sa_zero;
    assign inst_srlv = is_special && inst.r.funct == FN_SRLV && sa_zero;
    assign inst_srav = is_special && inst.r.funct == FN_SRAV && sa_zero;
    assign inst_jr   = is_special && inst.r.funct == FN_JR && rt_zero && rd_zero && sa_zero;
    assign inst_jalr = is_special && inst.r.funct == FN_JALR && rt_zero && sa_zero;

    // immediate forms
    assign inst_addiu = inst.i.op == OPC_ADDIU;
    assign inst_addi  = inst.i.op == OPC_ADDI;
    assign inst_slti  = inst.i.op == OPC_SLTI;
    assign inst_sltiu = inst.i.op == OPC_SLTIU;
    assign inst_andi  = inst.i.op == OPC_ANDI;
    assign inst_ori   = inst.i.op == OPC_ORI;
    assign inst_xori  = inst.i.op == OPC_XORI;
    assign inst_lui   = inst.i.op == OPC_LUI && inst.i.rs == 5'd0;
    assign inst_lw    = inst.i.op == OPC_LW;
    assign inst_sw    = inst.i.op == OPC_SW;

    // branches and jumps
    assign inst_beq  = inst.i.op == OPC_BEQ;
    assign inst_bne  = inst.i.op == OPC_BNE;
    assign inst_bgtz = inst.i.op == OPC_BGTZ && inst.i.rt == 5'd0;
    assign inst_blez = inst.i.op == OPC_BLEZ && inst.i.rt == 5'd0;
    assign inst_bgez = is_regimm && inst.i.rt == RT_BGEZ;
    assign inst_bltz = is_regimm && inst.i.rt == RT_BLTZ;
    assign inst_j    = inst.j.op == OPC_J;
    assign inst_jal  = inst.j.op == OPC_JAL;

    assign dst_is_r31 = inst_jal;
    assign dst_is_rt  = inst_addiu | inst_addi | inst_slti | inst_sltiu | inst_andi
                      | inst_ori | inst_xori | inst_lui | inst_lw;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_addu | inst_add | inst_addiu | inst_addi | inst_lw
                              | inst_sw | inst_jal | inst_jalr;  // link computes pc + 8
        ctrl.alu_op[ALU_SUB]  = inst_subu | inst_sub;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll | inst_sllv;
        ctrl.alu_op[ALU_SRL]  = inst_srl | inst_srlv;
        ctrl.alu_op[ALU_SRA]  = inst_sra | inst_srav;
        ctrl.alu_op[ALU_LUI]  = inst_lui;

        ctrl.src1_is_sa      = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc      = inst_jal | inst_jalr;
        ctrl.src2_is_imm     = dst_is_rt | inst_sw;
        ctrl.src2_is_8       = inst_jal | inst_jalr;
        ctrl.zero_extend_imm = inst_andi | inst_ori | inst_xori;
        ctrl.load_op         = inst_lw;
        ctrl.mem_we          = inst_sw;
        // anything outside the subset leaves gr_we low
        ctrl.gr_we = |ctrl.alu_op[ALU_LUI:ALU_SUB] | inst_addu | inst_add | inst_addiu
                   | inst_addi | inst_lw | inst_jal | inst_jalr;
        ctrl.dest = dst_is_r31 ? 5'd31 :
                    dst_is_rt  ? inst.i.rt :
                                 inst.r.rd;
        ctrl.imm  = inst.i.imm;

        if (inst_beq)                ctrl.br_kind = BR_BEQ;
        else if (inst_bne)           ctrl.br_kind = BR_BNE;
        else if (inst_bgez)          ctrl.br_kind = BR_BGEZ;
        else if (inst_bgtz)          ctrl.br_kind = BR_BGTZ;
        else if (inst_blez)          ctrl.br_kind = BR_BLEZ;
        else if (inst_bltz)          ctrl.br_kind = BR_BLTZ;
        else if (inst_j | inst_jal)  ctrl.br_kind = BR_J;
        else if (inst_jr | inst_jalr) ctrl.br_kind = BR_JR;
        else                         ctrl.br_kind = BR_NONE;
    end

endmodule

//--- source/stage_latch.sv
module stage_latch
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_to_ds_valid,
    input  fetch_bus_t fs_to_ds_bus,
    input  logic       ready_go,
    input  logic       es_allowin,
    output logic       ds_valid,
    output logic       ds_allowin,
    output logic       ds_to_es_valid,
    output fetch_bus_t ds_item
);

    // take a new item when empty or when the current one leaves this cycle
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_item <= fs_to_ds_bus;
        end
    end

endmodule

//--- source/decode_pkg.sv
package decode_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // one-hot alu operation, bit positions
    localparam int ALU_OP_W = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_REGIMM  = 6'h01;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_BLEZ    = 6'h06;
    localparam logic [5:0] OPC_BGTZ    = 6'h07;
    localparam logic [5:0] OPC_ADDI    = 6'h08;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // special function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // regimm rt field selects the compare
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    localparam int BR_KIND_W = 4;
    localparam logic [BR_KIND_W-1:0] BR_NONE = 4'd0;
    localparam logic [BR_KIND_W-1:0] BR_BEQ  = 4'd1;
    localparam logic [BR_KIND_W-1:0] BR_BNE  = 4'd2;
    localparam logic [BR_KIND_W-1:0] BR_BGEZ = 4'd3;
    localparam logic [BR_KIND_W-1:0] BR_BGTZ = 4'd4;
    localparam logic [BR_KIND_W-1:0] BR_BLEZ = 4'd5;
    localparam logic [BR_KIND_W-1:0] BR_BLTZ = 4'd6;
    localparam logic [BR_KIND_W-1:0] BR_J    = 4'd7;  // j and jal
    localparam logic [BR_KIND_W-1:0] BR_JR   = 4'd8;  // jr and jalr

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        sa;
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        op;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } mips_inst_u;

    typedef struct packed {
        mips_inst_u      inst;
        logic [XLEN-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        logic [ALU_OP_W-1:0]  alu_op;
        logic                 src1_is_sa;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 src2_is_8;
        logic                 zero_extend_imm;
        logic                 load_op;
        logic                 mem_we;
        logic                 gr_we;
        logic [REG_AW-1:0]    dest;
        logic [15:0]          imm;
        logic [BR_KIND_W-1:0] br_kind;
    } decode_ctrl_t;

    typedef struct packed {
        logic              valid;
        logic              gr_we;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   value;
    } fwd_src_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } rf_write_t;

    typedef struct packed {
        logic            stall;
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [XLEN-1:0] rs_value;
        logic [XLEN-1:0] rt_value;
        logic [XLEN-1:0] pc;
    } issue_bus_t;

endpackage
